/* Makefile */
VERILATOR ?= verilator
TOP ?= pipeline_core_tb
FILELIST ?= pipeline_core.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD_DIR)

/* dv/pipeline_core_tb.sv */
`timescale 1ns/100ps

module pipeline_core_tb;

    localparam int num_tests = 7;

    logic clk = 1'b0;
    logic i_reset;
    logic i_imem_we;
    logic [core_cfg_pkg::imem_addr_width-1:0] i_imem_addr;
    logic [core_isa_pkg::instr_width-1:0] i_imem_data;
    logic o_retire_valid;
    logic [core_isa_pkg::reg_addr_width-1:0] o_retire_rd;
    logic [core_isa_pkg::xlen-1:0] o_retire_data;
    logic o_store_valid;
    logic [core_isa_pkg::xlen-1:0] o_store_addr;
    logic [core_isa_pkg::xlen-1:0] o_store_data;
    logic o_halted;

    logic [31:0] progs [num_tests][256];
    int lens [num_tests];
    string names [num_tests];
    integer seed = 32'hc101_6efa;
    longint limit_cycles = 0;

    always #50 clk = ~clk;

    pipeline_core u_dut (
        .clk(clk), .i_reset(i_reset),
        .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr), .i_imem_data(i_imem_data),
        .o_retire_valid(o_retire_valid), .o_retire_rd(o_retire_rd),
        .o_retire_data(o_retire_data), .o_store_valid(o_store_valid),
        .o_store_addr(o_store_addr), .o_store_data(o_store_data), .o_halted(o_halted)
    );

    retire_checker u_checker (
        .clk(clk), .i_reset(i_reset),
        .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr), .i_imem_data(i_imem_data),
        .i_retire_valid(o_retire_valid), .i_retire_rd(o_retire_rd),
        .i_retire_data(o_retire_data), .i_store_valid(o_store_valid),
        .i_store_addr(o_store_addr), .i_store_data(o_store_data), .i_halted(o_halted)
    );

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, core_isa_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] sw_instr(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], core_isa_pkg::OPC_STORE};
    endfunction

    function automatic int pick(input int n);
        return {$random(seed)} % n;
    endfunction

    task automatic emit(input int t, input logic [31:0] w);
        progs[t][lens[t]] = w;
        lens[t]++;
    endtask

    // LUI then ADDI with the upper part rounded for the signed low half
    task automatic emit_li(input int t, input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] upper;
        upper = (v + 32'h800) >> 12;
        emit(t, {upper[19:0], rd, core_isa_pkg::OPC_LUI});
        emit(t, i_type(v[11:0], rd, 3'b000, rd, core_isa_pkg::OPC_OP_IMM));
    endtask

    task automatic emit_random_op(input int t, input logic [4:0] rd, input logic [4:0] rs1,
                                  input logic [4:0] rs2);
        logic [2:0] f3_tab [6];
        int k;
        f3_tab = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100, 3'b010};
        k = pick(6);
        emit(t, r_type((k == 1) ? 7'b0100000 : 7'b0, f3_tab[k], rd, rs1, rs2));
    endtask

    task automatic build_programs();
        logic [31:0] saddr [6];
        int w;
        foreach (lens[t])
            lens[t] = 0;
        names = '{"alu_ops", "dependences", "upper_imm", "load_store", "x0_writes",
                  "halt_first", "halt_second"};
        for (int r = 1; r < 16; r++)
            emit_li(0, 5'(r), $random(seed));
        for (int i = 0; i < 20; i++)
            emit_random_op(0, 5'(1 + pick(15)), 5'(1 + pick(15)), 5'(1 + pick(15)));
        // Distance one, two and three between producer and consumer
        emit_li(1, 5'd1, $random(seed));
        emit_li(1, 5'd2, $random(seed));
        for (int i = 0; i < 4; i++)
        begin
            emit_random_op(1, 5'd3, 5'd1, 5'd2);
            emit_random_op(1, 5'd4, 5'd3, 5'd1);
            emit(1, i_type(12'(pick(4096)), 5'd4, 3'b000, 5'd5, core_isa_pkg::OPC_OP_IMM));
            emit_random_op(1, 5'd6, 5'd3, 5'd1);
            emit_random_op(1, 5'd7, 5'd5, 5'd4);
            emit(1, core_isa_pkg::nop_instr);
            emit_random_op(1, 5'd1, 5'd2, 5'd5);
            emit_random_op(1, 5'd2, 5'd7, 5'd1);
        end
        for (int i = 0; i < 6; i++)
        begin
            emit(2, {20'($random(seed)), 5'(1 + i), core_isa_pkg::OPC_LUI});
            emit(2, {20'($random(seed)), 5'(8 + i), core_isa_pkg::OPC_AUIPC});
        end
        emit(2, r_type(7'b0, 3'b000, 5'd20, 5'd8, 5'd1));
        emit_li(3, 5'd20, 32'h100);
        for (int i = 0; i < 6; i++)
        begin
            w = pick(128);
            saddr[i] = 32'(w * 4);
            emit_li(3, 5'(1 + i), $random(seed));
            if (i % 2 == 0)
                emit(3, sw_instr(12'(w * 4), 5'(1 + i), 5'd0));
            else
                emit(3, sw_instr(12'(w * 4 - 256), 5'(1 + i), 5'd20));
        end
        for (int i = 0; i < 6; i++)
            emit(3, i_type(saddr[5 - i][11:0], 5'd0, 3'b010, 5'(10 + i),
                           core_isa_pkg::OPC_LOAD));
        emit(3, core_isa_pkg::nop_instr);
        emit(3, r_type(7'b0, 3'b000, 5'd16, 5'd10, 5'd15));
        emit_li(4, 5'd1, $random(seed));
        emit_li(4, 5'd2, $random(seed));
        emit(4, i_type(12'd5, 5'd0, 3'b000, 5'd0, core_isa_pkg::OPC_OP_IMM));
        emit(4, r_type(7'b0, 3'b000, 5'd0, 5'd1, 5'd2));
        emit(4, {20'h12345, 5'd0, core_isa_pkg::OPC_LUI});
        emit(4, r_type(7'b0, 3'b000, 5'd3, 5'd0, 5'd1));
        emit(4, r_type(7'b0100000, 3'b000, 5'd4, 5'd0, 5'd2));
        emit(4, sw_instr(12'h040, 5'd0, 5'd0));
        // Words after the halt jump must never execute
        emit_li(5, 5'd1, $random(seed));
        emit(5, i_type(12'd1, 5'd1, 3'b000, 5'd2, core_isa_pkg::OPC_OP_IMM));
        emit(5, sw_instr(12'd8, 5'd2, 5'd0));
        emit(5, core_isa_pkg::halt_instr);
        emit(5, i_type(12'd7, 5'd0, 3'b000, 5'd3, core_isa_pkg::OPC_OP_IMM));
        emit(5, sw_instr(12'd12, 5'd3, 5'd0));
        emit_li(6, 5'd6, $random(seed));
        emit(6, r_type(7'b0, 3'b000, 5'd7, 5'd6, 5'd6));
        emit(6, sw_instr(12'd16, 5'd7, 5'd0));
        emit(6, i_type(12'd16, 5'd0, 3'b010, 5'd8, core_isa_pkg::OPC_LOAD));
        emit(6, core_isa_pkg::nop_instr);
        emit(6, r_type(7'b0, 3'b000, 5'd9, 5'd8, 5'd7));
        for (int t = 0; t < num_tests; t++)
        begin
            if (t != 5)
                emit(t, core_isa_pkg::halt_instr);
        end
    endtask

    task automatic run_test(input int t);
        @(negedge clk);
        i_reset = 1'b1;
        for (int i = 0; i < lens[t]; i++)
        begin
            i_imem_we = 1'b1;
            i_imem_addr = 8'(i);
            i_imem_data = progs[t][i];
            @(negedge clk);
        end
        i_imem_we = 1'b0;
        @(posedge clk);
        u_checker.begin_test(names[t]);
        repeat (2) @(negedge clk);
        i_reset = 1'b0;
        while (o_halted !== 1'b1)
            @(negedge clk);
        repeat (4) @(posedge clk);
        u_checker.finish_test();
    endtask

    initial
    begin
        i_reset = 1'b1;
        i_imem_we = 1'b0;
        i_imem_addr = '0;
        i_imem_data = '0;
        build_programs();
        repeat (2) @(negedge clk);
        for (int t = 0; t < num_tests; t++)
            run_test(t);
        $display("Tests run: %0d, passed: %0d, failed: %0d", num_tests,
                 u_checker.tests_passed, u_checker.tests_failed);
        if (u_checker.tests_failed == 0 && u_checker.tests_passed == num_tests)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    // Twice the cycles of every program plus its pipeline drain
    initial
    begin
        wait (lens[num_tests-1] > 0);
        for (int t = 0; t < num_tests; t++)
            limit_cycles += 2 * (lens[t] + 10);
        #(limit_cycles * 100);
        $display("Watchdog expired: the core did not halt in %0d cycles", limit_cycles);
        $display("Testbench failed");
        $finish;
    end

endmodule

/* dv/retire_checker.sv */
`timescale 1ns/100ps

module retire_checker (
    input  logic clk,
    input  logic i_reset,
    input  logic i_imem_we,
    input  logic [core_cfg_pkg::imem_addr_width-1:0] i_imem_addr,
    input  logic [core_isa_pkg::instr_width-1:0] i_imem_data,
    input  logic i_retire_valid,
    input  logic [core_isa_pkg::reg_addr_width-1:0] i_retire_rd,
    input  logic [core_isa_pkg::xlen-1:0] i_retire_data,
    input  logic i_store_valid,
    input  logic [core_isa_pkg::xlen-1:0] i_store_addr,
    input  logic [core_isa_pkg::xlen-1:0] i_store_data,
    input  logic i_halted
);

    logic [31:0] prog [256];
    logic [31:0] mregs [32];
    logic [31:0] mdmem [256];
    logic [36:0] exp_retire [$];
    logic [63:0] exp_store [$];
    logic reset_q;
    string test_name;
    int test_errors;
    int tests_passed;
    int tests_failed;

    initial
    begin
        foreach (mregs[i])
            mregs[i] = '0;
        tests_passed = 0;
        tests_failed = 0;
        test_errors = 0;
        test_name = "none";
    end

    // Program image as it goes into the DUT
    always @(posedge clk)
    begin
        if (i_imem_we)
            prog[i_imem_addr] = i_imem_data;
    end

    // Reset as the DUT saw it at the last rising edge
    always @(posedge clk)
    begin
        reset_q <= i_reset;
    end

    function automatic logic [31:0] alu(input logic [2:0] f3, input logic sub,
                                        input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000: return sub ? a - b : a + b;
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b110: return a | b;
            3'b111: return a & b;
            default: return a + b;
        endcase
    endfunction

    // One instruction on the model state; {reg write, store, rd, addr, data}
    function automatic logic [70:0] model_step(input logic [31:0] ins, input logic [31:0] pc);
        logic [4:0] rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] res;
        logic [31:0] addr;
        logic is_reg;
        logic is_store;
        rd = ins[11:7];
        a = mregs[ins[19:15]];
        b = mregs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        is_reg = 1'b1;
        is_store = 1'b0;
        addr = '0;
        res = '0;
        case (ins[6:0])
            core_isa_pkg::OPC_OP: res = alu(ins[14:12], ins[30], a, b);
            core_isa_pkg::OPC_OP_IMM: res = alu(ins[14:12], 1'b0, a, imm_i);
            core_isa_pkg::OPC_LUI: res = {ins[31:12], 12'b0};
            core_isa_pkg::OPC_AUIPC: res = pc + {ins[31:12], 12'b0};
            core_isa_pkg::OPC_LOAD:
            begin
                addr = a + imm_i;
                res = mdmem[addr[9:2]];
            end
            core_isa_pkg::OPC_STORE:
            begin
                is_reg = 1'b0;
                is_store = 1'b1;
                addr = a + imm_s;
                res = b;
                mdmem[addr[9:2]] = b;
            end
            default: is_reg = 1'b0;
        endcase
        if (rd == 5'd0)
            is_reg = 1'b0;
        if (is_reg)
            mregs[rd] = res;
        return {is_reg, is_store, rd, addr, res};
    endfunction

    task automatic begin_test(input string name);
        logic [31:0] pc;
        logic [70:0] ev;
        int steps;
        test_name = name;
        exp_retire.delete();
        exp_store.delete();
        pc = '0;
        steps = 0;
        while (prog[pc[9:2]] !== core_isa_pkg::halt_instr && steps < 256)
        begin
            ev = model_step(prog[pc[9:2]], pc);
            if (ev[70])
                exp_retire.push_back({ev[68:64], ev[31:0]});
            if (ev[69])
                exp_store.push_back(ev[63:0]);
            pc = pc + 32'd4;
            steps++;
        end
    endtask

    task automatic finish_test();
        if (exp_retire.size() != 0 || exp_store.size() != 0)
        begin
            $display("%s: halted with %0d register writes and %0d stores still missing",
                     test_name, exp_retire.size(), exp_store.size());
            test_errors++;
        end
        if (test_errors == 0)
        begin
            tests_passed++;
            $display("Test %s: ok", test_name);
        end
        else
        begin
            tests_failed++;
            $display("Test %s: %0d errors", test_name, test_errors);
        end
        test_errors = 0;
    endtask

    // Outputs are sampled mid-cycle
    always @(negedge clk)
    begin
        logic [36:0] r;
        logic [63:0] s;
        if (reset_q === 1'b1 &&
            (i_retire_valid !== 1'b0 || i_store_valid !== 1'b0 || i_halted !== 1'b0))
        begin
            $display("Retire, store or halt output is not low while reset is held");
            test_errors++;
        end
        if (i_retire_valid === 1'b1)
        begin
            if (i_halted === 1'b1 || exp_retire.size() == 0)
            begin
                $display("%s: unexpected write of x%0d after the program ended",
                         test_name, i_retire_rd);
                test_errors++;
            end
            else
            begin
                r = exp_retire.pop_front();
                if (r !== {i_retire_rd, i_retire_data})
                begin
                    $display("Error: %s retire expected x%0d=%h, actual x%0d=%h",
                             test_name, r[36:32], r[31:0], i_retire_rd, i_retire_data);
                    test_errors++;
                end
            end
        end
        if (i_store_valid === 1'b1)
        begin
            if (i_halted === 1'b1 || exp_store.size() == 0)
            begin
                $display("%s: unexpected store to %h", test_name, i_store_addr);
                test_errors++;
            end
            else
            begin
                s = exp_store.pop_front();
                if (s !== {i_store_addr, i_store_data})
                begin
                    $display("Error: %s store expected [%h]=%h, actual [%h]=%h",
                             test_name, s[63:32], s[31:0], i_store_addr, i_store_data);
                    test_errors++;
                end
            end
        end
    end

endmodule

/* hdl/core_cfg_pkg.sv */
package core_cfg_pkg;

    // Instruction memory depth in 32-bit words
    localparam int imem_depth = 256;
    localparam int imem_addr_width = 8;

    // Data memory depth in 32-bit words
    localparam int dmem_depth = 256;
    localparam int dmem_addr_width = 8;

endpackage

/* hdl/core_isa_pkg.sv */
package core_isa_pkg;

    localparam int xlen = 32;
    localparam int instr_width = 32;
    localparam int reg_addr_width = 5;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    localparam logic [2:0] funct3_add_sub = 3'b000;
    localparam logic [2:0] funct3_slt = 3'b010;
    localparam logic [2:0] funct3_xor = 3'b100;
    localparam logic [2:0] funct3_or = 3'b110;
    localparam logic [2:0] funct3_and = 3'b111;
    localparam logic [6:0] funct7_sub = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    // ADDI x0, x0, 0
    localparam logic [instr_width-1:0] nop_instr = 32'h0000_0013;
    // JAL x0, 0 marks the end of a program
    localparam logic [instr_width-1:0] halt_instr = 32'h0000_006f;

endpackage

/* hdl/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
    input  logic clk,
    input  logic i_reset,
    input  logic [core_isa_pkg::xlen-1:0] i_pc,
    input  logic [core_isa_pkg::instr_width-1:0] i_instruction,
    input  logic i_wb_we,
    input  logic [core_isa_pkg::reg_addr_width-1:0] i_wb_rd,
    input  logic [core_isa_pkg::xlen-1:0] i_wb_data,
    output logic [core_isa_pkg::xlen-1:0] o_pc,
    output logic [core_isa_pkg::reg_addr_width-1:0] o_rs1,
    output logic [core_isa_pkg::reg_addr_width-1:0] o_rs2,
    output logic [core_isa_pkg::xlen-1:0] o_rs1_data,
    output logic [core_isa_pkg::xlen-1:0] o_rs2_data,
    output logic [core_isa_pkg::xlen-1:0] o_imm,
    output logic [core_isa_pkg::reg_addr_width-1:0] o_rd,
    output core_isa_pkg::alu_op_e o_alu_op,
    output logic o_alu_src,
    output logic o_auipc,
    output logic o_mem_write,
    output logic o_mem_to_reg,
    output logic o_reg_write,
    output logic o_halt
);

    logic [core_isa_pkg::xlen-1:0] regs [32];
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [core_isa_pkg::reg_addr_width-1:0] rs1, rs2, rd;
    logic [core_isa_pkg::xlen-1:0] imm_i, imm_s, imm_u, imm;
    core_isa_pkg::alu_op_e alu_op;
    logic alu_src, auipc, mem_write, mem_to_reg, reg_write, halt;

    assign opcode = i_instruction[6:0];
    assign rd = i_instruction[11:7];
    assign funct3 = i_instruction[14:12];
    assign rs1 = i_instruction[19:15];
    assign rs2 = i_instruction[24:20];
    assign funct7 = i_instruction[31:25];

    assign imm_i = {{20{i_instruction[31]}}, i_instruction[31:20]};
    assign imm_s = {{20{i_instruction[31]}}, i_instruction[31:25], i_instruction[11:7]};
    assign imm_u = {i_instruction[31:12], 12'b0};

    function automatic core_isa_pkg::alu_op_e funct3_to_alu(input logic [2:0] f3,
                                                            input logic sub);
        case (f3)
            core_isa_pkg::funct3_add_sub: return sub ? core_isa_pkg::ALU_SUB
                                                     : core_isa_pkg::ALU_ADD;
            core_isa_pkg::funct3_slt: return core_isa_pkg::ALU_SLT;
            core_isa_pkg::funct3_xor: return core_isa_pkg::ALU_XOR;
            core_isa_pkg::funct3_or: return core_isa_pkg::ALU_OR;
            core_isa_pkg::funct3_and: return core_isa_pkg::ALU_AND;
            default: return core_isa_pkg::ALU_ADD;
        endcase
    endfunction

    // Register read with the write-back value passed straight through
    function automatic logic [core_isa_pkg::xlen-1:0] read_reg(
        input logic [core_isa_pkg::reg_addr_width-1:0] idx);
        if (idx == '0)
            return '0;
        if (i_wb_we && i_wb_rd == idx)
            return i_wb_data;
        return regs[idx];
    endfunction

    always_comb
    begin
        alu_op = core_isa_pkg::ALU_ADD;
        alu_src = 1'b1;
        auipc = 1'b0;
        mem_write = 1'b0;
        mem_to_reg = 1'b0;
        reg_write = 1'b0;
        halt = 1'b0;
        imm = imm_i;
        case (opcode)
            core_isa_pkg::OPC_OP:
            begin
                alu_src = 1'b0;
                alu_op = funct3_to_alu(funct3, funct7 == core_isa_pkg::funct7_sub);
                reg_write = 1'b1;
            end
            core_isa_pkg::OPC_OP_IMM:
            begin
                alu_op = funct3_to_alu(funct3, 1'b0);
                reg_write = 1'b1;
            end
            core_isa_pkg::OPC_LUI:
            begin
                alu_op = core_isa_pkg::ALU_PASS_B;
                imm = imm_u;
                reg_write = 1'b1;
            end
            core_isa_pkg::OPC_AUIPC:
            begin
                auipc = 1'b1;
                imm = imm_u;
                reg_write = 1'b1;
            end
            core_isa_pkg::OPC_LOAD:
            begin
                mem_to_reg = 1'b1;
                reg_write = 1'b1;
            end
            core_isa_pkg::OPC_STORE:
            begin
                imm = imm_s;
                mem_write = 1'b1;
            end
            default:
            begin
                halt = (i_instruction == core_isa_pkg::halt_instr);
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (i_wb_we)
        begin
            regs[i_wb_rd] <= i_wb_data;
        end
    end

    always_ff @(posedge clk)
    begin
        o_pc <= i_pc;
        o_rs1 <= rs1;
        o_rs2 <= rs2;
        o_rs1_data <= read_reg(rs1);
        o_rs2_data <= read_reg(rs2);
        o_imm <= imm;
        o_rd <= rd;
        if (i_reset)
        begin
            o_alu_op <= core_isa_pkg::ALU_ADD;
            o_alu_src <= 1'b1;
            o_auipc <= 1'b0;
            o_mem_write <= 1'b0;
            o_mem_to_reg <= 1'b0;
            o_reg_write <= 1'b0;
            o_halt <= 1'b0;
        end
        else
        begin
            o_alu_op <= alu_op;
            o_alu_src <= alu_src;
            o_auipc <= auipc;
            o_mem_write <= mem_write;
            o_mem_to_reg <= mem_to_reg;
            o_reg_write <= reg_write;
            o_halt <= halt;
        end
    end

    assert property (@(posedge clk) disable iff (i_reset) !(o_mem_write && o_reg_write));

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage (
    input  logic clk,
    input  logic i_reset,
    input  logic [core_isa_pkg::xlen-1:0] i_pc,
    input  logic [core_isa_pkg::reg_addr_width-1:0] i_rs1,
    input  logic [core_isa_pkg::reg_addr_width-1:0] i_rs2,
    input  logic [core_isa_pkg::xlen-1:0] i_rs1_data,
    input  logic [core_isa_pkg::xlen-1:0] i_rs2_data,
    input  logic [core_isa_pkg::xlen-1:0] i_imm,
    input  logic [core_isa_pkg::reg_addr_width-1:0] i_rd,
    input  core_isa_pkg::alu_op_e i_alu_op,
    input  logic i_alu_src,
    input  logic i_auipc,
    input  logic i_mem_write,
    input  logic i_mem_to_reg,
    input  logic i_reg_write,
    input  logic i_halt,
    input  logic [core_isa_pkg::xlen-1:0] i_mem_fwd_data,
    input  logic i_wb_we,
    input  logic [core_isa_pkg::reg_addr_width-1:0] i_wb_rd,
    input  logic [core_isa_pkg::xlen-1:0] i_wb_data,
    output logic [core_isa_pkg::xlen-1:0] o_alu_result,
    output logic [core_isa_pkg::xlen-1:0] o_store_data,
    output logic [core_isa_pkg::reg_addr_width-1:0] o_rd,
    output logic o_mem_write,
    output logic o_mem_to_reg,
    output logic o_reg_write,
    output logic o_halt
);

    logic [core_isa_pkg::xlen-1:0] rs1_val, rs2_val, op_a, op_b, result;

    // Youngest producer wins so execute/memory goes before write-back
    function automatic logic [core_isa_pkg::xlen-1:0] forward(
        input logic [core_isa_pkg::reg_addr_width-1:0] idx,
        input logic [core_isa_pkg::xlen-1:0] rf_data);
        if (idx != '0 && o_reg_write && o_rd == idx)
            return i_mem_fwd_data;
        if (i_wb_we && i_wb_rd == idx)
            return i_wb_data;
        return rf_data;
    endfunction

    always_comb
    begin
        rs1_val = forward(i_rs1, i_rs1_data);
        rs2_val = forward(i_rs2, i_rs2_data);
    end

    assign op_a = i_auipc ? i_pc : rs1_val;
    assign op_b = i_alu_src ? i_imm : rs2_val;

    always_comb
    begin
        case (i_alu_op)
            core_isa_pkg::ALU_SUB: result = op_a - op_b;
            core_isa_pkg::ALU_AND: result = op_a & op_b;
            core_isa_pkg::ALU_OR: result = op_a | op_b;
            core_isa_pkg::ALU_XOR: result = op_a ^ op_b;
            core_isa_pkg::ALU_SLT: result = {31'b0, $signed(op_a) < $signed(op_b)};
            core_isa_pkg::ALU_PASS_B: result = op_b;
            default: result = op_a + op_b;
        endcase
    end

    always_ff @(posedge clk)
    begin
        o_alu_result <= result;
        o_store_data <= rs2_val;
        o_rd <= i_rd;
        if (i_reset)
        begin
            o_mem_write <= 1'b0;
            o_mem_to_reg <= 1'b0;
            o_reg_write <= 1'b0;
            o_halt <= 1'b0;
        end
        else
        begin
            o_mem_write <= i_mem_write;
            o_mem_to_reg <= i_mem_to_reg;
            o_reg_write <= i_reg_write;
            o_halt <= o_halt | i_halt;
        end
    end

    assert property (@(posedge clk) disable iff (i_reset) o_halt |=> o_halt);

endmodule

/* hdl/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage (
    input  logic clk,
    input  logic i_reset,
    input  logic i_imem_we,
    input  logic [core_cfg_pkg::imem_addr_width-1:0] i_imem_addr,
    input  logic [core_isa_pkg::instr_width-1:0] i_imem_data,
    output logic [core_isa_pkg::xlen-1:0] o_pc,
    output logic [core_isa_pkg::instr_width-1:0] o_instruction
);

    logic [core_isa_pkg::instr_width-1:0] imem [core_cfg_pkg::imem_depth];
    logic [core_isa_pkg::xlen-1:0] pc;
    logic [core_cfg_pkg::imem_addr_width-1:0] pc_index;
    logic [core_isa_pkg::instr_width-1:0] fetched;
    logic halted;

    assign pc_index = pc[core_cfg_pkg::imem_addr_width+1:2];
    // Only NOPs issue once the halt jump has gone by
    assign fetched = halted ? core_isa_pkg::nop_instr : imem[pc_index];

    always_ff @(posedge clk)
    begin
        if (i_imem_we)
        begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_reset)
        begin
            pc <= '0;
            halted <= 1'b0;
            o_pc <= '0;
            o_instruction <= core_isa_pkg::nop_instr;
        end
        else
        begin
            o_pc <= pc;
            o_instruction <= fetched;
            if (fetched == core_isa_pkg::halt_instr)
            begin
                halted <= 1'b1;
            end
            else if (!halted)
            begin
                pc <= pc + 32'd4;
            end
        end
    end

    // Program loading only under reset
    assert property (@(posedge clk) i_imem_we |-> i_reset);

endmodule

/* hdl/pipeline_core.sv */
`timescale 1ns/100ps

module pipeline_core (
    input  logic clk,
    input  logic i_reset,
    input  logic i_imem_we,
    input  logic [core_cfg_pkg::imem_addr_width-1:0] i_imem_addr,
    input  logic [core_isa_pkg::instr_width-1:0] i_imem_data,
    output logic o_retire_valid,
    output logic [core_isa_pkg::reg_addr_width-1:0] o_retire_rd,
    output logic [core_isa_pkg::xlen-1:0] o_retire_data,
    output logic o_store_valid,
    output logic [core_isa_pkg::xlen-1:0] o_store_addr,
    output logic [core_isa_pkg::xlen-1:0] o_store_data,
    output logic o_halted
);

    logic [core_isa_pkg::xlen-1:0] if_pc;
    logic [core_isa_pkg::instr_width-1:0] if_instruction;

    logic [core_isa_pkg::xlen-1:0] id_pc, id_rs1_data, id_rs2_data, id_imm;
    logic [core_isa_pkg::reg_addr_width-1:0] id_rs1, id_rs2, id_rd;
    core_isa_pkg::alu_op_e id_alu_op;
    logic id_alu_src, id_auipc, id_mem_write, id_mem_to_reg, id_reg_write, id_halt;

    logic [core_isa_pkg::xlen-1:0] ex_alu_result, ex_store_data, mem_fwd_data;
    logic [core_isa_pkg::reg_addr_width-1:0] ex_rd;
    logic ex_mem_write, ex_mem_to_reg, ex_reg_write, ex_halt;

    logic wb_we;
    logic [core_isa_pkg::reg_addr_width-1:0] wb_rd;
    logic [core_isa_pkg::xlen-1:0] wb_data;

    fetch_stage u_fetch (
        .clk(clk), .i_reset(i_reset),
        .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr), .i_imem_data(i_imem_data),
        .o_pc(if_pc), .o_instruction(if_instruction)
    );

    decode_stage u_decode (
        .clk(clk), .i_reset(i_reset),
        .i_pc(if_pc), .i_instruction(if_instruction),
        .i_wb_we(wb_we), .i_wb_rd(wb_rd), .i_wb_data(wb_data),
        .o_pc(id_pc), .o_rs1(id_rs1), .o_rs2(id_rs2),
        .o_rs1_data(id_rs1_data), .o_rs2_data(id_rs2_data), .o_imm(id_imm),
        .o_rd(id_rd), .o_alu_op(id_alu_op), .o_alu_src(id_alu_src),
        .o_auipc(id_auipc), .o_mem_write(id_mem_write), .o_mem_to_reg(id_mem_to_reg),
        .o_reg_write(id_reg_write), .o_halt(id_halt)
    );

    execute_stage u_execute (
        .clk(clk), .i_reset(i_reset),
        .i_pc(id_pc), .i_rs1(id_rs1), .i_rs2(id_rs2),
        .i_rs1_data(id_rs1_data), .i_rs2_data(id_rs2_data), .i_imm(id_imm),
        .i_rd(id_rd), .i_alu_op(id_alu_op), .i_alu_src(id_alu_src),
        .i_auipc(id_auipc), .i_mem_write(id_mem_write), .i_mem_to_reg(id_mem_to_reg),
        .i_reg_write(id_reg_write), .i_halt(id_halt),
        .i_mem_fwd_data(mem_fwd_data),
        .i_wb_we(wb_we), .i_wb_rd(wb_rd), .i_wb_data(wb_data),
        .o_alu_result(ex_alu_result), .o_store_data(ex_store_data), .o_rd(ex_rd),
        .o_mem_write(ex_mem_write), .o_mem_to_reg(ex_mem_to_reg),
        .o_reg_write(ex_reg_write), .o_halt(ex_halt)
    );

    result_stage u_result (
        .clk(clk), .i_reset(i_reset),
        .i_alu_result(ex_alu_result), .i_store_data(ex_store_data), .i_rd(ex_rd),
        .i_mem_write(ex_mem_write), .i_mem_to_reg(ex_mem_to_reg),
        .i_reg_write(ex_reg_write), .i_halt(ex_halt),
        .o_mem_fwd_data(mem_fwd_data),
        .o_wb_we(wb_we), .o_wb_rd(wb_rd), .o_wb_data(wb_data),
        .o_store_valid(o_store_valid), .o_store_addr(o_store_addr),
        .o_store_data(o_store_data), .o_halted(o_halted)
    );

    // Retire events are the write-back bus itself
    assign o_retire_valid = wb_we;
    assign o_retire_rd = wb_rd;
    assign o_retire_data = wb_data;

endmodule

/* hdl/result_stage.sv */
`timescale 1ns/100ps

module result_stage (
    input  logic clk,
    input  logic i_reset,
    input  logic [core_isa_pkg::xlen-1:0] i_alu_result,
    input  logic [core_isa_pkg::xlen-1:0] i_store_data,
    input  logic [core_isa_pkg::reg_addr_width-1:0] i_rd,
    input  logic i_mem_write,
    input  logic i_mem_to_reg,
    input  logic i_reg_write,
    input  logic i_halt,
    output logic [core_isa_pkg::xlen-1:0] o_mem_fwd_data,
    output logic o_wb_we,
    output logic [core_isa_pkg::reg_addr_width-1:0] o_wb_rd,
    output logic [core_isa_pkg::xlen-1:0] o_wb_data,
    output logic o_store_valid,
    output logic [core_isa_pkg::xlen-1:0] o_store_addr,
    output logic [core_isa_pkg::xlen-1:0] o_store_data,
    output logic o_halted
);

    logic [core_isa_pkg::xlen-1:0] dmem [core_cfg_pkg::dmem_depth];
    logic [core_cfg_pkg::dmem_addr_width-1:0] dmem_index;
    logic [core_isa_pkg::xlen-1:0] wb_alu_result, wb_mem_data;
    logic wb_mem_to_reg;

    assign dmem_index = i_alu_result[core_cfg_pkg::dmem_addr_width+1:2];
    assign o_mem_fwd_data = i_alu_result;

    // Store is reported in the cycle it writes
    assign o_store_valid = i_mem_write;
    assign o_store_addr = i_alu_result;
    assign o_store_data = i_store_data;

    always_ff @(posedge clk)
    begin
        if (i_mem_write)
        begin
            dmem[dmem_index] <= i_store_data;
        end
    end

    always_ff @(posedge clk)
    begin
        wb_alu_result <= i_alu_result;
        wb_mem_data <= dmem[dmem_index];
        wb_mem_to_reg <= i_mem_to_reg;
        o_wb_rd <= i_rd;
        if (i_reset)
        begin
            o_wb_we <= 1'b0;
            o_halted <= 1'b0;
        end
        else
        begin
            // x0 writes never reach the register file
            o_wb_we <= i_reg_write && (i_rd != '0);
            o_halted <= o_halted | i_halt;
        end
    end

    assign o_wb_data = wb_mem_to_reg ? wb_mem_data : wb_alu_result;

endmodule

/* pipeline_core.f */
hdl/core_isa_pkg.sv
hdl/core_cfg_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/pipeline_core.sv
dv/retire_checker.sv
dv/pipeline_core_tb.sv
